// File: verilog.f
hw/fsab_pkg.sv
hw/fsab_port_fifo.sv
hw/fsab_grant_mux.sv
hw/fsab_arbiter.sv
tests/tb_fsab_arbiter.sv

// File: Makefile
TOP = tb_fsab_arbiter

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: tests/tb_fsab_arbiter.sv
`timescale 1ns/1ps

module tb_fsab_arbiter import fsab_pkg::*; ();

	localparam int N_ROWS = 13; // requests in the stimulus table.
	localparam logic [31:0] SEED = 32'hd683_148e;
	localparam int EXP_DEPTH = 64; // expected beats per port.
	localparam int QUIET_CYC = 20;
	localparam int STALL_PORT = 2; // port loaded past its credits.

	typedef struct packed {
		logic [FSAB_PORT_W-1:0] port;
		logic [FSAB_REQ_W-1:0] mode;
		logic [FSAB_DID_W-1:0] did; // unique per port, names the port on the fabric.
		logic [FSAB_DID_W-1:0] subdid;
		logic [FSAB_ADDR_W-1:0] addr;
		logic [FSAB_LEN_W-1:0] len;
		logic [31:0] seed; // mixed into the xorshift seed.
	} row_t;

	typedef struct packed {
		logic [FSAB_REQ_W-1:0] mode;
		logic [FSAB_DID_W-1:0] did;
		logic [FSAB_DID_W-1:0] subdid;
		logic [FSAB_ADDR_W-1:0] addr;
		logic [FSAB_LEN_W-1:0] len;
		logic [FSAB_DATA_W-1:0] data;
		logic [FSAB_MASK_W-1:0] mask;
		logic chk_data; // reads carry a dummy word.
	} beat_t;

	logic clk = 1'b0;
	logic Nrst;
	logic [FSAB_PORTS-1:0] inp_valid;
	logic [FSAB_REQ_W-1:0] inp_mode [FSAB_PORTS];
	logic [FSAB_DID_W-1:0] inp_did [FSAB_PORTS];
	logic [FSAB_DID_W-1:0] inp_subdid [FSAB_PORTS];
	logic [FSAB_ADDR_W-1:0] inp_addr [FSAB_PORTS];
	logic [FSAB_LEN_W-1:0] inp_len [FSAB_PORTS];
	logic [FSAB_DATA_W-1:0] inp_data [FSAB_PORTS];
	logic [FSAB_MASK_W-1:0] inp_mask [FSAB_PORTS];
	logic [FSAB_PORTS-1:0] inp_credit;
	logic out_valid;
	logic [FSAB_REQ_W-1:0] out_mode;
	logic [FSAB_DID_W-1:0] out_did;
	logic [FSAB_DID_W-1:0] out_subdid;
	logic [FSAB_ADDR_W-1:0] out_addr;
	logic [FSAB_LEN_W-1:0] out_len;
	logic [FSAB_DATA_W-1:0] out_data;
	logic [FSAB_MASK_W-1:0] out_mask;

	fsab_arbiter dut_i (
		.clk        (clk),
		.Nrst       (Nrst),
		.inp_valid  (inp_valid),
		.inp_mode   (inp_mode),
		.inp_did    (inp_did),
		.inp_subdid (inp_subdid),
		.inp_addr   (inp_addr),
		.inp_len    (inp_len),
		.inp_data   (inp_data),
		.inp_mask   (inp_mask),
		.inp_credit (inp_credit),
		.out_valid  (out_valid),
		.out_mode   (out_mode),
		.out_did    (out_did),
		.out_subdid (out_subdid),
		.out_addr   (out_addr),
		.out_len    (out_len),
		.out_data   (out_data),
		.out_mask   (out_mask)
	);

	always #20 clk = ~clk; // 40 ns period.

	// --------------------------------------------------
	// master models, one request stream per port
	// --------------------------------------------------
	row_t stim [N_ROWS];
	beat_t exp_mem [FSAB_PORTS][EXP_DEPTH];
	int exp_wr [FSAB_PORTS]; // written by the masters.
	int exp_rd [FSAB_PORTS]; // advanced by the fabric monitor.
	int row_ptr [FSAB_PORTS];
	int beat_no [FSAB_PORTS];
	int beats_tot [FSAB_PORTS];
	int sent [FSAB_PORTS]; // requests begun, each costs a credit.
	int cred_cnt [FSAB_PORTS];
	int stall_cyc [FSAB_PORTS]; // cycles a request waited for a credit.
	row_t cur [FSAB_PORTS];
	logic [31:0] rng [FSAB_PORTS];
	logic [FSAB_PORTS-1:0] first_beat; // beat that carries a new header.

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic drive_port(input int p);
		logic [FSAB_DATA_W-1:0] data;
		if (beat_no[p] == 0) begin
			while (row_ptr[p] < N_ROWS && int'(stim[row_ptr[p]].port) != p)
				row_ptr[p]++;
			if (row_ptr[p] < N_ROWS && sent[p] - cred_cnt[p] >= FSAB_CREDITS)
				stall_cyc[p]++; // request ready, no credit left.
			if (row_ptr[p] >= N_ROWS || sent[p] - cred_cnt[p] >= FSAB_CREDITS) begin
				inp_valid[p] = 1'b0; // done, or stalled for credit.
				first_beat[p] = 1'b0;
				return;
			end
			cur[p] = stim[row_ptr[p]];
			row_ptr[p]++;
			sent[p]++;
			rng[p] = SEED ^ cur[p].seed;
			beats_tot[p] = (cur[p].mode == FSAB_WRITE) ? int'(cur[p].len) : 1;
		end
		rng[p] = xorshift(rng[p]);
		data[63:32] = rng[p];
		rng[p] = xorshift(rng[p]);
		data[31:0] = rng[p];
		rng[p] = xorshift(rng[p]); // low byte is the mask.
		inp_valid[p] = 1'b1;
		first_beat[p] = (beat_no[p] == 0);
		inp_mode[p] = cur[p].mode;
		inp_did[p] = cur[p].did;
		inp_subdid[p] = cur[p].subdid;
		inp_addr[p] = cur[p].addr;
		inp_len[p] = cur[p].len;
		inp_data[p] = data;
		inp_mask[p] = rng[p][7:0];
		exp_mem[p][exp_wr[p]] = {cur[p].mode, cur[p].did, cur[p].subdid, cur[p].addr,
			cur[p].len, data, rng[p][7:0], cur[p].mode == FSAB_WRITE};
		exp_wr[p]++;
		beat_no[p]++;
		if (beat_no[p] == beats_tot[p])
			beat_no[p] = 0;
	endtask

	// --------------------------------------------------
	// fabric monitor and scoreboard
	// --------------------------------------------------
	int hdr_cnt [FSAB_PORTS]; // headers taken, up to the last edge.
	int hdr_lag [FSAB_PORTS]; // same, one edge older, as seen by the grant.
	int started [FSAB_PORTS];
	int done [FSAB_PORTS]; // requests whose last beat has left.
	int last_port = FSAB_PORTS - 1; // grant pointer starts at port 0.
	int cur_port;
	int beats_left;
	int mon_err;

	task automatic check_field(input string name, input logic [63:0] got,
		input logic [63:0] exp_v);
		assert (got === exp_v) else begin
			$display("FAILED %s: got %h expected %h", name, got, exp_v);
			mon_err++;
		end
	endtask

	task automatic check_beat();
		int p;
		int want;
		int q;
		beat_t e;
		p = -1;
		for (int i = 0; i < FSAB_PORTS; i++)
			if (exp_rd[i] < exp_wr[i] && exp_mem[i][exp_rd[i]].did == out_did)
				p = i;
		assert (p >= 0) else begin
			$display("output beat with device id %h matches no outstanding request", out_did);
			mon_err++;
		end
		if (p < 0)
			return;
		e = exp_mem[p][exp_rd[p]];
		if (beats_left == 0) begin
			want = -1; // next port with a header, counting up from the last grant.
			for (int i = 1; i <= FSAB_PORTS; i++) begin
				q = (last_port + i) % FSAB_PORTS;
				if (want < 0 && hdr_lag[q] > started[q])
					want = q;
			end
			assert (p == want) else begin
				$display("FAILED granted port (out_did %h): got %h expected %h", out_did, p, want);
				mon_err++;
			end
			started[p]++;
			last_port = p;
			cur_port = p;
			beats_left = (e.mode == FSAB_WRITE) ? int'(e.len) : 1;
		end else begin
			assert (p == cur_port) else begin
				$display("beat of port %0d arrived inside a request of port %0d", p, cur_port);
				mon_err++;
			end
		end
		check_field("out_mode", 64'(out_mode), 64'(e.mode));
		check_field("out_subdid", 64'(out_subdid), 64'(e.subdid));
		check_field("out_addr", 64'(out_addr), 64'(e.addr));
		check_field("out_len", 64'(out_len), 64'(e.len));
		if (e.chk_data) begin
			check_field("out_data", out_data, e.data);
			check_field("out_mask", 64'(out_mask), 64'(e.mask));
		end
		exp_rd[p]++;
		beats_left--;
		if (beats_left == 0)
			done[p]++; // last beat of the request.
	endtask

	always @(posedge clk) begin
		if (Nrst) begin
			for (int p = 0; p < FSAB_PORTS; p++) begin
				if (inp_credit[p])
					cred_cnt[p]++;
				assert (cred_cnt[p] <= done[p]) else begin
					$display("port %0d returned a credit before its request left the fabric", p);
					mon_err++;
				end
			end
			if (out_valid)
				check_beat();
			hdr_lag = hdr_cnt;
			for (int p = 0; p < FSAB_PORTS; p++)
				if (inp_valid[p] && first_beat[p])
					hdr_cnt[p]++;
		end
	end

	// --------------------------------------------------
	// run control, watchdog and summary
	// --------------------------------------------------
	int limit_cyc;
	int tests_run;
	int tests_failed;

	initial begin
		wait (limit_cyc != 0);
		repeat (limit_cyc) @(posedge clk);
		$display("timeout: no completion within %0d cycles", limit_cyc);
		$display("RESULT: FAIL");
		$finish;
	end

	task automatic expect_quiet(output int errs);
		errs = 0;
		repeat (QUIET_CYC) begin
			@(posedge clk);
			assert (!out_valid && inp_credit == '0) else begin
				$display("FAILED out_valid/inp_credit: got %h/%h expected 0/0",
					out_valid, inp_credit);
				errs++;
			end
		end
	endtask

	task automatic report_test(input string name, input int errs);
		tests_run++;
		if (errs == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errs);
		end
	endtask

	function automatic bit all_sent();
		int n;
		n = 0;
		for (int p = 0; p < FSAB_PORTS; p++)
			n += (beat_no[p] == 0) ? sent[p] : N_ROWS + 1; // mid-burst never counts as done.
		return n == N_ROWS;
	endfunction

	function automatic int credits_back();
		return cred_cnt[0] + cred_cnt[1] + cred_cnt[2];
	endfunction

	initial begin
		int errs;
		int rows;
		int beats;
		Nrst = 1'b0;
		inp_valid = '0;
		first_beat = '0;
		for (int p = 0; p < FSAB_PORTS; p++) begin
			inp_mode[p] = '0;
			inp_did[p] = '0;
			inp_subdid[p] = '0;
			inp_addr[p] = '0;
			inp_len[p] = '0;
			inp_data[p] = '0;
			inp_mask[p] = '0;
		end
		// port 2 sends four max-length writes back to back and then waits for a credit.
		stim = '{
			'{2'd0, FSAB_WRITE, 4'h8, 4'h1, 31'h0010_0000, 4'd8, 32'h0000_0011},
			'{2'd1, FSAB_WRITE, 4'h9, 4'h2, 31'h0020_0000, 4'd8, 32'h0000_0022},
			'{2'd2, FSAB_WRITE, 4'ha, 4'h3, 31'h0030_0000, 4'd8, 32'h0000_0033},
			'{2'd0, FSAB_READ,  4'h8, 4'h4, 31'h7fff_fff0, 4'd1, 32'h0000_0044},
			'{2'd1, FSAB_READ,  4'h9, 4'h5, 31'h0020_0100, 4'd2, 32'h0000_0055},
			'{2'd2, FSAB_WRITE, 4'ha, 4'h6, 31'h0030_0008, 4'd8, 32'h0000_0066},
			'{2'd2, FSAB_WRITE, 4'ha, 4'h7, 31'h0030_0010, 4'd8, 32'h0000_0077},
			'{2'd0, FSAB_WRITE, 4'h8, 4'h8, 31'h0010_0040, 4'd3, 32'h0000_0088},
			'{2'd2, FSAB_WRITE, 4'ha, 4'h9, 31'h0030_0018, 4'd8, 32'h0000_0099},
			'{2'd1, FSAB_WRITE, 4'h9, 4'ha, 31'h0020_0200, 4'd1, 32'h0000_00aa},
			'{2'd2, FSAB_READ,  4'ha, 4'hb, 31'h0030_3000, 4'd1, 32'h0000_00bb},
			'{2'd0, FSAB_WRITE, 4'h8, 4'hc, 31'h0010_0080, 4'd5, 32'h0000_00cc},
			'{2'd0, FSAB_READ,  4'h8, 4'hd, 31'h0010_00c0, 4'd1, 32'h0000_00dd}
		};
		beats = 0;
		for (int i = 0; i < N_ROWS; i++)
			beats += (stim[i].mode == FSAB_WRITE) ? int'(stim[i].len) : 1;
		limit_cyc = beats * FSAB_LEN_MAX * FSAB_PORTS * 8 + 10 + 2 * QUIET_CYC;
		repeat (10) @(posedge clk);
		@(negedge clk);
		Nrst = 1'b1;
		expect_quiet(errs);
		report_test("reset quiet", errs);

		do begin
			@(negedge clk);
			for (int p = 0; p < FSAB_PORTS; p++)
				drive_port(p);
		end while (!all_sent());
		@(negedge clk);
		inp_valid = '0;
		first_beat = '0;
		while (credits_back() != N_ROWS)
			@(negedge clk); // last credit pulse ends the traffic.

		for (int p = 0; p < FSAB_PORTS; p++) begin
			errs = 0;
			rows = 0;
			for (int i = 0; i < N_ROWS; i++)
				rows += (int'(stim[i].port) == p) ? 1 : 0;
			assert (cred_cnt[p] == rows) else begin
				$display("FAILED inp_credit[%0d] pulses: got %h expected %h", p, cred_cnt[p], rows);
				errs++;
			end
			assert (exp_rd[p] == exp_wr[p]) else begin
				$display("port %0d has %0d beats never seen on the fabric", p, exp_wr[p] - exp_rd[p]);
				errs++;
			end
			report_test($sformatf("port %0d traffic", p), errs);
		end
		errs = 0;
		assert (stall_cyc[STALL_PORT] > 0) else begin
			$display("port %0d never waited for a credit", STALL_PORT);
			errs++;
		end
		report_test("credit stall", errs);
		expect_quiet(errs);
		report_test("drain quiet", errs);
		report_test("fabric beats", mon_err);

		$display("tests run %0d, passed %0d, failed %0d", tests_run, tests_run - tests_failed,
			tests_failed);
		if (tests_failed == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: hw/fsab_arbiter.sv
`timescale 1ns/1ps

module fsab_arbiter import fsab_pkg::*; (
	input  logic                   clk,
	input  logic                   Nrst,

	input  logic [FSAB_PORTS-1:0]  inp_valid,
	input  logic [FSAB_REQ_W-1:0]  inp_mode [FSAB_PORTS],
	input  logic [FSAB_DID_W-1:0]  inp_did [FSAB_PORTS],
	input  logic [FSAB_DID_W-1:0]  inp_subdid [FSAB_PORTS],
	input  logic [FSAB_ADDR_W-1:0] inp_addr [FSAB_PORTS],
	input  logic [FSAB_LEN_W-1:0]  inp_len [FSAB_PORTS],
	input  logic [FSAB_DATA_W-1:0] inp_data [FSAB_PORTS],
	input  logic [FSAB_MASK_W-1:0] inp_mask [FSAB_PORTS],
	output logic [FSAB_PORTS-1:0]  inp_credit,

	output logic                   out_valid,
	output logic [FSAB_REQ_W-1:0]  out_mode,
	output logic [FSAB_DID_W-1:0]  out_did,
	output logic [FSAB_DID_W-1:0]  out_subdid,
	output logic [FSAB_ADDR_W-1:0] out_addr,
	output logic [FSAB_LEN_W-1:0]  out_len,
	output logic [FSAB_DATA_W-1:0] out_data,
	output logic [FSAB_MASK_W-1:0] out_mask
);

	// --------------------------------------------------
	// port fifo outputs toward the grant unit
	// --------------------------------------------------
	logic [FSAB_PORTS-1:0] port_valid;
	logic [FSAB_REQ_W-1:0] port_mode [FSAB_PORTS];
	logic [FSAB_DID_W-1:0] port_did [FSAB_PORTS];
	logic [FSAB_DID_W-1:0] port_subdid [FSAB_PORTS];
	logic [FSAB_ADDR_W-1:0] port_addr [FSAB_PORTS];
	logic [FSAB_LEN_W-1:0] port_len [FSAB_PORTS];
	logic [FSAB_DATA_W-1:0] port_data [FSAB_PORTS];
	logic [FSAB_MASK_W-1:0] port_mask [FSAB_PORTS];
	logic [FSAB_PORTS-1:0] empty_b; // header waiting, per port.
	logic [FSAB_PORTS-1:0] active; // request in flight, per port.
	logic [FSAB_PORTS-1:0] start; // one-hot start from the grant unit.

	for (genvar g = 0; g < FSAB_PORTS; g++) begin : g_port
		fsab_port_fifo port_fifo_i (
			.clk        (clk),
			.Nrst       (Nrst),
			.inp_valid  (inp_valid[g]),
			.inp_mode   (inp_mode[g]),
			.inp_did    (inp_did[g]),
			.inp_subdid (inp_subdid[g]),
			.inp_addr   (inp_addr[g]),
			.inp_len    (inp_len[g]),
			.inp_data   (inp_data[g]),
			.inp_mask   (inp_mask[g]),
			.inp_credit (inp_credit[g]),
			.out_valid  (port_valid[g]),
			.out_mode   (port_mode[g]),
			.out_did    (port_did[g]),
			.out_subdid (port_subdid[g]),
			.out_addr   (port_addr[g]),
			.out_len    (port_len[g]),
			.out_data   (port_data[g]),
			.out_mask   (port_mask[g]),
			.empty_b    (empty_b[g]),
			.start      (start[g]),
			.active     (active[g])
		);
	end

	// --------------------------------------------------
	// arbitration onto the single fabric bus
	// --------------------------------------------------
	fsab_grant_mux grant_mux_i (
		.clk         (clk),
		.Nrst        (Nrst),
		.empty_b     (empty_b),
		.active      (active),
		.start       (start),
		.port_valid  (port_valid),
		.port_mode   (port_mode),
		.port_did    (port_did),
		.port_subdid (port_subdid),
		.port_addr   (port_addr),
		.port_len    (port_len),
		.port_data   (port_data),
		.port_mask   (port_mask),
		.out_valid   (out_valid),
		.out_mode    (out_mode),
		.out_did     (out_did),
		.out_subdid  (out_subdid),
		.out_addr    (out_addr),
		.out_len     (out_len),
		.out_data    (out_data),
		.out_mask    (out_mask)
	);

endmodule

// File: hw/fsab_grant_mux.sv
`timescale 1ns/1ps

module fsab_grant_mux import fsab_pkg::*; (
	input  logic                   clk,
	input  logic                   Nrst,

	input  logic [FSAB_PORTS-1:0]  empty_b,
	input  logic [FSAB_PORTS-1:0]  active,
	output logic [FSAB_PORTS-1:0]  start,

	input  logic [FSAB_PORTS-1:0]  port_valid,
	input  logic [FSAB_REQ_W-1:0]  port_mode [FSAB_PORTS],
	input  logic [FSAB_DID_W-1:0]  port_did [FSAB_PORTS],
	input  logic [FSAB_DID_W-1:0]  port_subdid [FSAB_PORTS],
	input  logic [FSAB_ADDR_W-1:0] port_addr [FSAB_PORTS],
	input  logic [FSAB_LEN_W-1:0]  port_len [FSAB_PORTS],
	input  logic [FSAB_DATA_W-1:0] port_data [FSAB_PORTS],
	input  logic [FSAB_MASK_W-1:0] port_mask [FSAB_PORTS],

	output logic                   out_valid,
	output logic [FSAB_REQ_W-1:0]  out_mode,
	output logic [FSAB_DID_W-1:0]  out_did,
	output logic [FSAB_DID_W-1:0]  out_subdid,
	output logic [FSAB_ADDR_W-1:0] out_addr,
	output logic [FSAB_LEN_W-1:0]  out_len,
	output logic [FSAB_DATA_W-1:0] out_data,
	output logic [FSAB_MASK_W-1:0] out_mask
);

	// --------------------------------------------------
	// round-robin selection
	// --------------------------------------------------
	logic [FSAB_PORT_W-1:0] ptr_q; // first port to look at.
	logic [FSAB_PORT_W-1:0] gnt_q; // port whose outputs reach the fabric.
	logic start_pend_q; // start went out last cycle, active not yet seen.
	logic [FSAB_PORT_W-1:0] pick;
	logic found;
	logic bus_free;
	logic grant;

	// scan from the far end so the lowest offset from ptr_q wins.
	always_comb begin
		int unsigned idx;
		pick = ptr_q;
		found = 1'b0;
		for (int i = FSAB_PORTS - 1; i >= 0; i--) begin
			idx = ptr_q + i;
			if (idx >= FSAB_PORTS)
				idx = idx - FSAB_PORTS; // wrap around the port ring.
			if (empty_b[idx]) begin
				pick = FSAB_PORT_W'(idx);
				found = 1'b1;
			end
		end
	end

	assign bus_free = !(|active) && !start_pend_q;
	assign grant = bus_free && found;
	assign start = grant ? (FSAB_PORTS'(1) << pick) : '0; // one-hot pulse.

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			ptr_q <= '0;
			gnt_q <= '0;
			start_pend_q <= 1'b0;
		end else begin
			start_pend_q <= grant;
			if (grant) begin
				gnt_q <= pick; // held until the next grant.
				ptr_q <= (pick == FSAB_PORT_W'(FSAB_PORTS - 1)) ? '0 : pick + 1'b1;
			end
		end
	end

	// --------------------------------------------------
	// output steering
	// --------------------------------------------------
	assign out_valid = port_valid[gnt_q];
	assign out_mode = port_mode[gnt_q];
	assign out_did = port_did[gnt_q];
	assign out_subdid = port_subdid[gnt_q];
	assign out_addr = port_addr[gnt_q];
	assign out_len = port_len[gnt_q];
	assign out_data = port_data[gnt_q];
	assign out_mask = port_mask[gnt_q];

endmodule

// File: hw/fsab_port_fifo.sv
`timescale 1ns/1ps

module fsab_port_fifo import fsab_pkg::*; (
	input  logic                   clk,
	input  logic                   Nrst,

	input  logic                   inp_valid,
	input  logic [FSAB_REQ_W-1:0]  inp_mode,
	input  logic [FSAB_DID_W-1:0]  inp_did,
	input  logic [FSAB_DID_W-1:0]  inp_subdid,
	input  logic [FSAB_ADDR_W-1:0] inp_addr,
	input  logic [FSAB_LEN_W-1:0]  inp_len,
	input  logic [FSAB_DATA_W-1:0] inp_data,
	input  logic [FSAB_MASK_W-1:0] inp_mask,
	output logic                   inp_credit,

	output logic                   out_valid,
	output logic [FSAB_REQ_W-1:0]  out_mode,
	output logic [FSAB_DID_W-1:0]  out_did,
	output logic [FSAB_DID_W-1:0]  out_subdid,
	output logic [FSAB_ADDR_W-1:0] out_addr,
	output logic [FSAB_LEN_W-1:0]  out_len,
	output logic [FSAB_DATA_W-1:0] out_data,
	output logic [FSAB_MASK_W-1:0] out_mask,

	output logic                   empty_b,
	input  logic                   start,
	output logic                   active
);

	// --------------------------------------------------
	// request fifo, one header per request
	// --------------------------------------------------
	logic [FSAB_RFIF_ENTRY_W-1:0] rfif_mem [FSAB_CREDITS];
	logic [FSAB_CREDIT_W-1:0] rfif_wpos; // write pointer with wrap bit.
	logic [FSAB_CREDIT_W-1:0] rfif_rpos; // read pointer with wrap bit.
	logic [FSAB_RFIF_ENTRY_W-1:0] rfif_q; // header of the request being served.
	logic rfif_wr;
	logic rfif_rd;
	logic rfif_empty;
	logic [FSAB_LEN_W-1:0] in_rem; // trailing write beats still to come in.
	logic in_idle;

	assign rfif_empty = (rfif_rpos == rfif_wpos); // pointers equal incl. wrap bit.
	assign in_idle = (in_rem == '0); // next valid beat opens a request.
	assign rfif_wr = inp_valid && in_idle; // only the first beat carries a header.

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			rfif_wpos <= '0;
			rfif_rpos <= '0;
			in_rem <= '0;
		end else begin
			if (rfif_wr)
				rfif_wpos <= rfif_wpos + 1'b1;
			if (rfif_rd)
				rfif_rpos <= rfif_rpos + 1'b1;
			if (inp_valid) begin
				if (in_idle) begin
					if (inp_mode == FSAB_WRITE && inp_len > 1)
						in_rem <= inp_len - 1'b1; // first beat already taken.
				end else begin
					in_rem <= in_rem - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rfif_wr)
			rfif_mem[rfif_wpos[FSAB_CREDIT_W-2:0]] <= {inp_mode, inp_did, inp_subdid,
				inp_addr, inp_len};
		if (rfif_rd)
			rfif_q <= rfif_mem[rfif_rpos[FSAB_CREDIT_W-2:0]]; // held for the whole burst.
	end

	assign {out_mode, out_did, out_subdid, out_addr, out_len} = rfif_q;

	// --------------------------------------------------
	// data fifo, one entry per valid beat
	// --------------------------------------------------
	logic [FSAB_DFIF_ENTRY_W-1:0] dfif_mem [FSAB_DFIF_DEPTH];
	logic [FSAB_DFIF_W-1:0] dfif_wpos;
	logic [FSAB_DFIF_W-1:0] dfif_rpos;
	logic [FSAB_DFIF_ENTRY_W-1:0] dfif_q; // beat on the output.
	logic dfif_rd;
	logic dfif_more; // read for a trailing write beat.
	logic dfif_empty;

	assign dfif_empty = (dfif_rpos == dfif_wpos);

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			dfif_wpos <= '0;
			dfif_rpos <= '0;
		end else begin
			if (inp_valid)
				dfif_wpos <= dfif_wpos + 1'b1; // reads store a dummy word too.
			if (dfif_rd)
				dfif_rpos <= dfif_rpos + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (inp_valid)
			dfif_mem[dfif_wpos[FSAB_DFIF_W-2:0]] <= {inp_data, inp_mask};
		if (dfif_rd)
			dfif_q <= dfif_mem[dfif_rpos[FSAB_DFIF_W-2:0]];
	end

	assign {out_data, out_mask} = dfif_q;

	// --------------------------------------------------
	// readout sequencing and credit return
	// --------------------------------------------------
	logic rfif_rd_1a; // header on the output this cycle.
	logic rfif_rd_2a; // one cycle after the header beat.
	logic dfif_rd_1a; // data beat on the output this cycle.
	logic busy; // trailing write beats being drained.
	logic busy_1a;
	logic [FSAB_LEN_W-1:0] out_rem; // beats of the burst not yet read.

	assign empty_b = !rfif_empty; // a header waits, data may still be arriving.

	// start is only taken while idle; the header and first beat leave together.
	assign rfif_rd = start && !rfif_empty && !busy && !rfif_rd_1a;
	assign dfif_more = busy && (out_mode == FSAB_WRITE) && (out_rem > 1) && !dfif_empty;
	assign dfif_rd = rfif_rd || dfif_more;

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			rfif_rd_1a <= 1'b0;
			rfif_rd_2a <= 1'b0;
			dfif_rd_1a <= 1'b0;
			busy <= 1'b0;
			busy_1a <= 1'b0;
			out_rem <= '0;
		end else begin
			rfif_rd_1a <= rfif_rd;
			rfif_rd_2a <= rfif_rd_1a;
			dfif_rd_1a <= dfif_rd;
			busy_1a <= busy;
			if (rfif_rd_1a && out_mode == FSAB_WRITE) begin
				busy <= 1'b1; // header out, one pause cycle follows.
				out_rem <= out_len;
			end else if (dfif_more) begin
				out_rem <= out_rem - 1'b1;
			end else if (out_rem <= 1) begin
				busy <= 1'b0; // last data read issued.
			end
		end
	end

	// write credit follows the fall of busy, read credit follows its only beat.
	assign inp_credit = (busy_1a && !busy) || (rfif_rd_2a && out_mode == FSAB_READ);
	assign active = rfif_rd_1a || rfif_rd_2a || busy || busy_1a; // up to the credit cycle.
	assign out_valid = dfif_rd_1a;

endmodule

// File: hw/fsab_pkg.sv
package fsab_pkg;

	// --------------------------------------------------
	// request header fields
	// --------------------------------------------------
	localparam int FSAB_REQ_W = 1; // mode field.
	localparam logic [FSAB_REQ_W-1:0] FSAB_READ = 1'b0; // single-beat read.
	localparam logic [FSAB_REQ_W-1:0] FSAB_WRITE = 1'b1; // burst write.

	localparam int FSAB_DID_W = 4; // device id and sub-device id.
	localparam int FSAB_ADDR_W = 31; // word address.
	localparam int FSAB_LEN_W = 4; // burst length.
	localparam int FSAB_LEN_MAX = 8; // longest write burst in words.

	// --------------------------------------------------
	// data beat fields
	// --------------------------------------------------
	localparam int FSAB_DATA_W = 64; // one data word.
	localparam int FSAB_MASK_W = 8; // one bit per byte lane.

	// --------------------------------------------------
	// credits and buffering
	// --------------------------------------------------
	localparam int FSAB_CREDITS = 4; // initial credits, also request fifo depth.
	localparam int FSAB_CREDIT_W = 3; // request fifo pointer with wrap bit.

	// worst case every outstanding request is a full-length write.
	localparam int FSAB_DFIF_DEPTH = FSAB_CREDITS * FSAB_LEN_MAX;
	localparam int FSAB_DFIF_W = 6; // data fifo pointer with wrap bit.

	// packed entry widths of the two fifos.
	localparam int FSAB_RFIF_ENTRY_W = FSAB_REQ_W + 2 * FSAB_DID_W + FSAB_ADDR_W + FSAB_LEN_W;
	localparam int FSAB_DFIF_ENTRY_W = FSAB_DATA_W + FSAB_MASK_W;

	// --------------------------------------------------
	// fabric ports
	// --------------------------------------------------
	localparam int FSAB_PORTS = 3; // masters on the arbiter.
	localparam int FSAB_PORT_W = 2; // port index.

endpackage
